//--- verilog/route_cfg.svh
/* Bus and register-map sizes for the routing register block
   Included by the package and every RTL file */
`ifndef ROUTE_CFG_SVH
`define ROUTE_CFG_SVH

//////////////////////////////////////////////////
// AXI4-Lite bus widths
//////////////////////////////////////////////////

// Data bus, fixed at 32 bits
`define ROUTE_DATA_W 32
// Byte address, covers eight word slots
`define ROUTE_ADDR_W 5
// One strobe per data byte
`define ROUTE_STRB_W 4

//////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////

// Lowest address bit that selects a word
`define ROUTE_ADDR_LSB 2
// Word index width taken from the address
`define ROUTE_IDX_W 3
// Implemented registers, slot 7 is unmapped
`define ROUTE_NUM_REGS 7

`endif

//--- verilog/route_pkg.sv
/* Shared types of the routing register block
   Channel states, AXI response code, bank write bundle and routing controls */
`include "route_cfg.svh"

package route_pkg;

  //////////////////////////////////////////////////
  // AXI response and channel states
  //////////////////////////////////////////////////

  // AXI response code, only OKAY is produced here
  typedef enum logic [1:0]
  {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } route_resp_e;

  // Write side, WR_RESP means bvalid is up
  typedef enum logic
  {
    WR_IDLE = 1'b0,
    WR_RESP = 1'b1
  } wr_state_e;

  // Read side, RD_DATA means rvalid is up
  typedef enum logic
  {
    RD_IDLE = 1'b0,
    RD_DATA = 1'b1
  } rd_state_e;

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////

  // One write into the register bank
  typedef struct packed
  {
    logic                     en;
    logic [`ROUTE_IDX_W-1:0]  idx;
    logic [`ROUTE_DATA_W-1:0] data;
    logic [`ROUTE_STRB_W-1:0] strb;
  } reg_wr_t;

  // Routing controls decoded from register 0
  typedef struct packed
  {
    logic       adc_sw_dest0;
    logic       adc_sw_dest1;
    logic       adc_ddr_sw_0_tdest;
    logic       dac_ddr_sw_0_tdest;
    logic       adc_ddr_sw_1_tdest;
    logic       dac_ddr_sw_1_tdest;
    logic [1:0] swrite_bypass;
  } route_ctrl_t;

endpackage

//--- verilog/axi_wr_port.sv
/* AXI4-Lite write address, write data and write response channels
   Takes address and data together and hands one strobed write to the bank */
`include "route_cfg.svh"

module axi_wr_port
  import route_pkg::*;
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  logic [`ROUTE_ADDR_W-1:0] awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [`ROUTE_DATA_W-1:0] wdata,
  input  logic [`ROUTE_STRB_W-1:0] wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output route_resp_e              bresp,
  output logic                     bvalid,
  input  logic                     bready,
  output reg_wr_t                  reg_wr
);

  wr_state_e               wr_state;
  // Word index captured when the write is first seen
  logic [`ROUTE_IDX_W-1:0] wr_idx;
  logic                    both_valid;
  logic                    wr_fire;

  assign both_valid = awvalid && wvalid;
  // Handshake cycle on both channels
  assign wr_fire = awready && wready && both_valid;

  //////////////////////////////////////////////////
  // Ready pulses and response state
  //////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      awready  <= 1'b0;
      wready   <= 1'b0;
      wr_state <= WR_IDLE;
    end
    else
    begin
      // One-cycle pulse, blocked while a response is pending
      awready <= (wr_state == WR_IDLE) && !awready && both_valid;
      wready  <= (wr_state == WR_IDLE) && !wready && both_valid;
      case (wr_state)
        WR_IDLE:
        begin
          if (wr_fire)
          begin
            wr_state <= WR_RESP;
          end
        end
        WR_RESP:
        begin
          // Master took the response
          if (bready)
          begin
            wr_state <= WR_IDLE;
          end
        end
        default:
        begin
          wr_state <= WR_IDLE;
        end
      endcase
    end
  end

  // Address slice latched on the cycle before the ready pulse
  always_ff @(posedge S_AXI_ACLK)
  begin
    if ((wr_state == WR_IDLE) && !awready && both_valid)
    begin
      wr_idx <= awaddr[`ROUTE_ADDR_LSB +: `ROUTE_IDX_W];
    end
  end

  //////////////////////////////////////////////////
  // Bank write and response
  //////////////////////////////////////////////////

  // Data and strobes are still held by the master during the handshake
  assign reg_wr.en   = wr_fire;
  assign reg_wr.idx  = wr_idx;
  assign reg_wr.data = wdata;
  assign reg_wr.strb = wstrb;

  assign bvalid = (wr_state == WR_RESP);
  assign bresp  = RESP_OKAY;

  // Response held until the master takes it
  a_bvalid_hold: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    bvalid && !bready |=> bvalid);

  // Address and data channels always accepted together
  a_ready_pair: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    awready == wready);

endmodule

//--- verilog/axi_rd_port.sv
/* AXI4-Lite read address and read data channels
   Selects a bank word by index and returns it as registered read data */
`include "route_cfg.svh"

module axi_rd_port
  import route_pkg::*;
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  logic [`ROUTE_ADDR_W-1:0] araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [`ROUTE_DATA_W-1:0] rdata,
  output route_resp_e              rresp,
  output logic                     rvalid,
  input  logic                     rready,
  output logic [`ROUTE_IDX_W-1:0]  rd_idx,
  input  logic [`ROUTE_DATA_W-1:0] rd_word
);

  rd_state_e rd_state;
  logic      rd_seen;
  logic      rd_fire;

  // New read seen with nothing outstanding
  assign rd_seen = (rd_state == RD_IDLE) && !arready && arvalid;
  assign rd_fire = arready && arvalid;

  //////////////////////////////////////////////////
  // Address acceptance and data state
  //////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      arready  <= 1'b0;
      rd_state <= RD_IDLE;
    end
    else
    begin
      arready <= rd_seen;
      case (rd_state)
        RD_IDLE:
        begin
          if (rd_fire)
          begin
            rd_state <= RD_DATA;
          end
        end
        RD_DATA:
        begin
          if (rready)
          begin
            rd_state <= RD_IDLE;
          end
        end
        default:
        begin
          rd_state <= RD_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Index and data capture
  //////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (rd_seen)
    begin
      rd_idx <= araddr[`ROUTE_ADDR_LSB +: `ROUTE_IDX_W];
    end
    // Bank word as it stands at the end of the arready pulse
    if (rd_fire && (rd_state == RD_IDLE))
    begin
      rdata <= rd_word;
    end
  end

  assign rvalid = (rd_state == RD_DATA);
  assign rresp  = RESP_OKAY;

  // Read data frozen while the master stalls
  a_rdata_hold: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

//--- verilog/route_reg_bank.sv
/* Seven strobed control registers with read mux and routing decode
   Written by the write port, read by index from the read port */
`include "route_cfg.svh"

module route_reg_bank
  import route_pkg::*;
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  reg_wr_t                  reg_wr,
  input  logic [`ROUTE_IDX_W-1:0]  rd_idx,
  output logic [`ROUTE_DATA_W-1:0] rd_word,
  output route_ctrl_t              route
);

  // Control registers, slot 7 has no storage
  logic [`ROUTE_DATA_W-1:0] regs [`ROUTE_NUM_REGS];
  logic                     wr_hit;

  // Write lands on an implemented slot
  assign wr_hit = reg_wr.en && (reg_wr.idx < `ROUTE_NUM_REGS);

  //////////////////////////////////////////////////
  // Register write with byte strobes
  //////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      for (int r = 0; r < `ROUTE_NUM_REGS; r++)
      begin
        regs[r] <= '0;
      end
    end
    else if (wr_hit)
    begin
      // Only strobed byte lanes change
      for (int b = 0; b < `ROUTE_STRB_W; b++)
      begin
        if (reg_wr.strb[b])
        begin
          regs[reg_wr.idx][b*8 +: 8] <= reg_wr.data[b*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb
  begin
    // Unmapped slot reads as zero
    rd_word = '0;
    if (rd_idx < `ROUTE_NUM_REGS)
    begin
      rd_word = regs[rd_idx];
    end
  end

  //////////////////////////////////////////////////
  // Routing decode of register 0
  //////////////////////////////////////////////////

  // ADC sink destinations
  assign route.adc_sw_dest0 = regs[0][0];
  assign route.adc_sw_dest1 = regs[0][1];

  // Stream switch 0, clear gives the ADC path
  assign route.adc_ddr_sw_0_tdest = ~regs[0][2];
  assign route.dac_ddr_sw_0_tdest = regs[0][2];

  // Stream switch 1, same rule
  assign route.adc_ddr_sw_1_tdest = ~regs[0][3];
  assign route.dac_ddr_sw_1_tdest = regs[0][3];

  // SRIO write bypass
  assign route.swrite_bypass = regs[0][5:4];

  // A register only moves on a write aimed at it
  for (genvar i = 0; i < `ROUTE_NUM_REGS; i++)
  begin : g_hold
    a_reg_hold: assert property (
      @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      !(wr_hit && (reg_wr.idx == i)) |=> $stable(regs[i]));
  end

endmodule

//--- verilog/routing_reg.sv
/* Top of the AXI4-Lite routing register block
   Joins the write port, the read port and the register bank */
`include "route_cfg.svh"

module routing_reg
  import route_pkg::*;
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  // Write address
  input  logic [`ROUTE_ADDR_W-1:0] s_axi_awaddr,
  input  logic                     s_axi_awvalid,
  output logic                     s_axi_awready,
  // Write data
  input  logic [`ROUTE_DATA_W-1:0] s_axi_wdata,
  input  logic [`ROUTE_STRB_W-1:0] s_axi_wstrb,
  input  logic                     s_axi_wvalid,
  output logic                     s_axi_wready,
  // Write response
  output route_resp_e              s_axi_bresp,
  output logic                     s_axi_bvalid,
  input  logic                     s_axi_bready,
  // Read address
  input  logic [`ROUTE_ADDR_W-1:0] s_axi_araddr,
  input  logic                     s_axi_arvalid,
  output logic                     s_axi_arready,
  // Read data
  output logic [`ROUTE_DATA_W-1:0] s_axi_rdata,
  output route_resp_e              s_axi_rresp,
  output logic                     s_axi_rvalid,
  input  logic                     s_axi_rready,
  // Decoded routing controls
  output route_ctrl_t              route
);

  reg_wr_t                  reg_wr;
  logic [`ROUTE_IDX_W-1:0]  rd_idx;
  logic [`ROUTE_DATA_W-1:0] rd_word;

  // Write channels into the bank
  axi_wr_port u_wr (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (s_axi_awaddr),
    .awvalid       (s_axi_awvalid),
    .awready       (s_axi_awready),
    .wdata         (s_axi_wdata),
    .wstrb         (s_axi_wstrb),
    .wvalid        (s_axi_wvalid),
    .wready        (s_axi_wready),
    .bresp         (s_axi_bresp),
    .bvalid        (s_axi_bvalid),
    .bready        (s_axi_bready),
    .reg_wr        (reg_wr)
  );

  // Read channels out of the bank
  axi_rd_port u_rd (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (s_axi_araddr),
    .arvalid       (s_axi_arvalid),
    .arready       (s_axi_arready),
    .rdata         (s_axi_rdata),
    .rresp         (s_axi_rresp),
    .rvalid        (s_axi_rvalid),
    .rready        (s_axi_rready),
    .rd_idx        (rd_idx),
    .rd_word       (rd_word)
  );

  route_reg_bank u_bank (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .reg_wr        (reg_wr),
    .rd_idx        (rd_idx),
    .rd_word       (rd_word),
    .route         (route)
  );

endmodule

//--- tests/tb_clk_gen.sv
/* Free-running testbench clock with a period of 8 time units */
module tb_clk_gen
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
  end

  // Half period of 4
  always #4 clk = ~clk;

endmodule

//--- tests/tb_routing_reg.sv
/* Directed tests of the AXI4-Lite routing register block
   Drives the bus on rising edges, samples on falling edges, models registers in a shadow array */
`include "route_cfg.svh"

module tb_routing_reg
  import route_pkg::*;
;

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int WAIT_LIMIT     = 64;

  logic                     aclk;
  logic                     aresetn;
  logic [`ROUTE_ADDR_W-1:0] s_axi_awaddr;
  logic                     s_axi_awvalid;
  logic                     s_axi_awready;
  logic [`ROUTE_DATA_W-1:0] s_axi_wdata;
  logic [`ROUTE_STRB_W-1:0] s_axi_wstrb;
  logic                     s_axi_wvalid;
  logic                     s_axi_wready;
  route_resp_e              s_axi_bresp;
  logic                     s_axi_bvalid;
  logic                     s_axi_bready;
  logic [`ROUTE_ADDR_W-1:0] s_axi_araddr;
  logic                     s_axi_arvalid;
  logic                     s_axi_arready;
  logic [`ROUTE_DATA_W-1:0] s_axi_rdata;
  route_resp_e              s_axi_rresp;
  logic                     s_axi_rvalid;
  logic                     s_axi_rready;
  route_ctrl_t              route;

  // Expected register contents
  logic [`ROUTE_DATA_W-1:0] shadow [`ROUTE_NUM_REGS];
  int word_errs;
  int route_errs;
  int resp_errs;
  int flag_errs;
  int wait_errs;
  int cycles;

  tb_clk_gen u_clk (.clk(aclk));

  routing_reg dut0 (
    .S_AXI_ACLK    (aclk),
    .S_AXI_ARESETN (aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .route         (route)
  );

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
      word_errs++;
    end
  endtask

  task automatic check_route(input route_ctrl_t got, input route_ctrl_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH time=%0t route got=%b exp=%b", $time, got, exp);
      route_errs++;
    end
  endtask

  task automatic check_resp(input string name, input route_resp_e got, input route_resp_e exp);
    if (got !== exp)
    begin
      $display("MISMATCH time=%0t %s got=%s exp=%s", $time, name, got.name(), exp.name());
      resp_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp);
      flag_errs++;
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Strobed byte lanes replace the old bytes
  // Slot 7 has no storage
  function automatic void model_write(input logic [4:0] addr, input logic [31:0] data,
                                      input logic [3:0] strb);
    logic [2:0] idx;
    idx = addr[4:2];
    if (idx != 3'd7)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (strb[b])
        begin
          shadow[idx][b*8 +: 8] = data[b*8 +: 8];
        end
      end
    end
  endfunction

  function automatic logic [31:0] expected_word(input logic [4:0] addr);
    if (addr[4:2] == 3'd7)
    begin
      return 32'h0;
    end
    return shadow[addr[4:2]];
  endfunction

  // Bits 2 and 3 steer the switches
  // A clear bit means the ADC path
  function automatic route_ctrl_t expected_route(input logic [31:0] word);
    route_ctrl_t r;
    r.adc_sw_dest0       = word[0];
    r.adc_sw_dest1       = word[1];
    r.adc_ddr_sw_0_tdest = !word[2];
    r.dac_ddr_sw_0_tdest = word[2];
    r.adc_ddr_sw_1_tdest = !word[3];
    r.dac_ddr_sw_1_tdest = word[3];
    r.swrite_bypass      = word[5:4];
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////

  task automatic start_write(input logic [4:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    @(posedge aclk);
    s_axi_awaddr  <= addr;
    s_axi_awvalid <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= strb;
    s_axi_wvalid  <= 1'b1;
    model_write(addr, data, strb);
  endtask

  // Hold address and data until the ready pulse
  // Valids drop at the handshake edge
  task automatic accept_write();
    int n;
    n = 0;
    @(negedge aclk);
    while (!s_axi_awready && n < WAIT_LIMIT)
    begin
      @(negedge aclk);
      n++;
    end
    if (!s_axi_awready)
    begin
      $display("Write was never accepted by the DUT at time %0t", $time);
      wait_errs++;
    end
    else
    begin
      // Data channel taken in the same cycle
      check_bit("wready", s_axi_wready, 1'b1);
    end
    @(posedge aclk);
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid  <= 1'b0;
  endtask

  task automatic wait_bresp();
    int n;
    n = 0;
    @(negedge aclk);
    while (!s_axi_bvalid && n < WAIT_LIMIT)
    begin
      @(negedge aclk);
      n++;
    end
    if (!s_axi_bvalid)
    begin
      $display("No write response arrived at time %0t", $time);
      wait_errs++;
    end
    else
    begin
      check_resp("bresp", s_axi_bresp, RESP_OKAY);
    end
  endtask

  // Full write with bready already high
  task automatic do_write(input logic [4:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    start_write(addr, data, strb);
    accept_write();
    wait_bresp();
    @(posedge aclk);
  endtask

  // Read with rready held low for hold cycles once rvalid is up
  task automatic do_read(input logic [4:0] addr, input int hold, output logic [31:0] data);
    int n;
    n = 0;
    @(posedge aclk);
    s_axi_araddr  <= addr;
    s_axi_arvalid <= 1'b1;
    s_axi_rready  <= (hold == 0);
    @(negedge aclk);
    while (!s_axi_arready && n < WAIT_LIMIT)
    begin
      @(negedge aclk);
      n++;
    end
    if (!s_axi_arready)
    begin
      $display("Read address was never accepted at time %0t", $time);
      wait_errs++;
    end
    @(posedge aclk);
    s_axi_arvalid <= 1'b0;
    n = 0;
    @(negedge aclk);
    while (!s_axi_rvalid && n < WAIT_LIMIT)
    begin
      @(negedge aclk);
      n++;
    end
    if (!s_axi_rvalid)
    begin
      $display("No read data arrived at time %0t", $time);
      wait_errs++;
    end
    check_resp("rresp", s_axi_rresp, RESP_OKAY);
    data = s_axi_rdata;
    if (hold > 0)
    begin
      // Stalled data must not move
      repeat (hold)
      begin
        @(negedge aclk);
        check_bit("rvalid", s_axi_rvalid, 1'b1);
        check_word("rdata", s_axi_rdata, data);
      end
      @(posedge aclk);
      s_axi_rready <= 1'b1;
    end
    @(posedge aclk);
  endtask

  task automatic read_check(input logic [4:0] addr);
    logic [31:0] got;
    do_read(addr, 0, got);
    check_word("rdata", got, expected_word(addr));
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_reset_values();
    for (int a = 0; a < 8; a++)
    begin
      read_check(5'(a * 4));
    end
    check_route(route, expected_route(32'h0));
  endtask

  task automatic test_full_words();
    for (int r = 0; r < `ROUTE_NUM_REGS; r++)
    begin
      do_write(5'(r * 4), $urandom(), 4'hf);
      read_check(5'(r * 4));
    end
  endtask

  // Single lanes first
  task automatic test_byte_strobes();
    for (int b = 0; b < 4; b++)
    begin
      do_write(5'((b + 1) * 4), $urandom(), 4'(1 << b));
      read_check(5'((b + 1) * 4));
    end
    // Every mixed pattern after that
    for (int s = 0; s < 16; s++)
    begin
      if (s != 1 && s != 2 && s != 4 && s != 8)
      begin
        do_write(5'((s % 7) * 4), $urandom(), 4'(s));
        read_check(5'((s % 7) * 4));
      end
    end
  endtask

  task automatic test_unmapped();
    do_write(5'h1c, $urandom(), 4'hf);
    for (int a = 0; a < 8; a++)
    begin
      read_check(5'(a * 4));
    end
  endtask

  // Walking ones over bits 0 to 5 and a few mixes
  task automatic test_route_decode();
    logic [31:0] data;
    logic [5:0]  bits;
    for (int i = 0; i < 9; i++)
    begin
      bits = (i < 6) ? 6'(1 << i) : ((i == 6) ? 6'h3f : ((i == 7) ? 6'h15 : 6'h2a));
      data = $urandom();
      data[5:0] = bits;
      do_write(5'h00, data, 4'hf);
      check_route(route, expected_route(shadow[0]));
    end
    read_check(5'h00);
  endtask

  task automatic test_back_pressure();
    logic [31:0] got;
    @(posedge aclk);
    s_axi_bready <= 1'b0;
    start_write(5'h08, $urandom(), 4'hf);
    accept_write();
    wait_bresp();
    // Second write offered while the first response is held
    start_write(5'h0c, $urandom(), 4'hf);
    repeat (6)
    begin
      @(negedge aclk);
      check_bit("bvalid", s_axi_bvalid, 1'b1);
      check_bit("awready", s_axi_awready, 1'b0);
      check_bit("wready", s_axi_wready, 1'b0);
    end
    @(posedge aclk);
    s_axi_bready <= 1'b1;
    accept_write();
    wait_bresp();
    @(posedge aclk);
    read_check(5'h08);
    do_read(5'h0c, 5, got);
    check_word("rdata", got, expected_word(5'h0c));
  endtask

  //////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'h6c79536e));
    aresetn       = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b1;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b1;
    for (int r = 0; r < `ROUTE_NUM_REGS; r++)
    begin
      shadow[r] = '0;
    end
    repeat (16) @(posedge aclk);
    aresetn <= 1'b1;
    test_reset_values();
    test_full_words();
    test_byte_strobes();
    test_unmapped();
    test_route_decode();
    test_back_pressure();
    repeat (4) @(posedge aclk);
    $display("Errors: data %0d, route %0d, response %0d, flag %0d, wait %0d",
             word_errs, route_errs, resp_errs, flag_errs, wait_errs);
    if (word_errs + route_errs + resp_errs + flag_errs + wait_errs == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog on the cycle count
  always @(posedge aclk)
  begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

endmodule

//--- list.f
+incdir+verilog
verilog/route_pkg.sv
verilog/axi_wr_port.sv
verilog/axi_rd_port.sv
verilog/route_reg_bank.sv
verilog/routing_reg.sv
tests/tb_clk_gen.sv
tests/tb_routing_reg.sv

//--- Makefile
# Verilator build and run of the routing register testbench

SIM = obj_dir/Vtb_routing_reg

.PHONY: all run clean

all: run

$(SIM): list.f verilog/route_cfg.svh verilog/route_pkg.sv verilog/axi_wr_port.sv \
        verilog/axi_rd_port.sv verilog/route_reg_bank.sv verilog/routing_reg.sv \
        tests/tb_clk_gen.sv tests/tb_routing_reg.sv
	verilator --binary --timing --assert -f list.f --top-module tb_routing_reg \
	  -o Vtb_routing_reg

# Pass only when the log holds the pass line
run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
